// ==== axo_core.f ====
+incdir+bench
hdl/axo_pkg.sv
hdl/axo_dx_if.sv
hdl/axo_alu.sv
hdl/axo_regfile.sv
hdl/axo_fetch.sv
hdl/axo_decode.sv
hdl/axo_execute.sv
hdl/axo_core.sv
bench/axo_core_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the core testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module axo_core_tb \
    -f axo_core.f \
    -Mdir obj_dir

# Exit status is nonzero when the testbench stops with $fatal.
./obj_dir/Vaxo_core_tb

// ==== bench/axo_core_tests.svh ====
// Instruction encoders and directed tests

    function automatic logic [31:0] r_type(int f7, int rs2, int rs1, int f3, int rd);
        return {7'(f7), 5'(rs2), 5'(rs1), 3'(f3), 5'(rd), OP_REG};
    endfunction

    function automatic logic [31:0] i_type(logic [6:0] opc, int rd, int f3, int rs1, int imm);
        return {12'(imm), 5'(rs1), 3'(f3), 5'(rd), opc};
    endfunction

    // Word store only.
    function automatic logic [31:0] s_type(int rs2, int rs1, int imm);
        logic [11:0] i12;
        i12 = 12'(imm);
        return {i12[11:5], 5'(rs2), 5'(rs1), 3'b010, i12[4:0], OP_STORE};
    endfunction

    function automatic logic [31:0] b_type(int f3, int rs1, int rs2, int off);
        logic [12:0] o;
        o = 13'(off);
        return {o[12], o[10:5], 5'(rs2), 5'(rs1), 3'(f3), o[4:1], o[11], OP_BRANCH};
    endfunction

    function automatic logic [31:0] u_type(logic [6:0] opc, int rd, logic [31:0] imm20);
        return {imm20[19:0], 5'(rd), opc};
    endfunction

    function automatic logic [31:0] j_type(int rd, int off);
        logic [20:0] o;
        o = 21'(off);
        return {o[20], o[10:1], o[11], o[19:12], 5'(rd), OP_JAL};
    endfunction

    function automatic logic [31:0] sext12(logic [31:0] v);
        return {{20{v[11]}}, v[11:0]};
    endfunction

    // ISA result of OP and OP-IMM where alt picks SUB or SRA.
    function automatic logic [31:0] isa_result(int f3, bit alt, logic [31:0] a, logic [31:0] b);
        case (f3)
            0: return alt ? a - b : a + b;
            1: return a << b[4:0];
            2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3: return (a < b) ? 32'd1 : 32'd0;
            4: return a ^ b;
            5: begin
                // Sign fill for SRA.
                if (alt) begin
                    return $signed(a) >>> b[4:0];
                end else begin
                    return a >> b[4:0];
                end
            end
            6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic bit branch_taken(int f3, logic [31:0] a, logic [31:0] b);
        case (f3)
            0: return a == b;
            1: return a != b;
            4: return $signed(a) < $signed(b);
            5: return $signed(a) >= $signed(b);
            6: return a < b;
            default: return a >= b;
        endcase
    endfunction

    // LUI plus ADDI with rounding for the signed low part.
    task automatic load_const(int rd, logic [31:0] value);
        logic [31:0] hi;
        hi = (value + 32'h800) >> 12;
        emit(u_type(OP_LUI, rd, hi));
        emit(i_type(OP_IMM, rd, 0, rd, int'(value)));
    endtask

    // Store to the next slot and expect it only when live.
    task automatic save(int rs2, logic [31:0] value, bit live);
        emit(s_type(rs2, 0, int'(slot)));
        if (live) begin
            exp_addr.push_back(slot);
            exp_data.push_back(value);
        end
        slot = slot + 32'd4;
    endtask

    // x31 reserved for the end marker.
    task automatic finish_program();
        load_const(31, 32'h0000_1000);
        emit(s_type(0, 31, -4));
    endtask

    task automatic reset_entry();
        begin_test();
        finish_program();
        run_program("reset");
    endtask

    task automatic arith_ops();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [31:0] pc;
        begin_test();
        a = $random(seed);
        b = $random(seed);
        load_const(1, a);
        load_const(2, b);
        for (int f3 = 0; f3 < 8; f3++) begin
            emit(r_type(0, 2, 1, f3, 3));
            save(3, isa_result(f3, 1'b0, a, b), 1'b1);
            if (f3 == 0 || f3 == 5) begin
                emit(r_type(32, 2, 1, f3, 3));
                save(3, isa_result(f3, 1'b1, a, b), 1'b1);
            end
            imm = sext12($random(seed));
            // Shifts take a 5-bit amount.
            if (f3 == 1 || f3 == 5) begin
                imm = {27'b0, imm[4:0]};
            end
            emit(i_type(OP_IMM, 3, f3, 1, int'(imm)));
            save(3, isa_result(f3, 1'b0, a, imm), 1'b1);
            if (f3 == 5) begin
                emit(i_type(OP_IMM, 3, f3, 1, int'(imm | 32'h400)));
                save(3, isa_result(f3, 1'b1, a, imm), 1'b1);
            end
        end
        imm = $random(seed);
        emit(u_type(OP_LUI, 4, imm));
        save(4, {imm[19:0], 12'b0}, 1'b1);
        pc = pc_now();
        emit(u_type(OP_AUIPC, 4, imm));
        save(4, pc + {imm[19:0], 12'b0}, 1'b1);
        finish_program();
        run_program("arith");
    endtask

    task automatic forward_chain();
        logic [31:0] c;
        logic [31:0] k;
        logic [31:0] v5;
        logic [31:0] v6;
        logic [31:0] v7;
        logic [31:0] v8;
        begin_test();
        c = $random(seed);
        k = sext12($random(seed));
        v5 = c + k;
        v6 = v5 + c;
        v7 = v6 ^ v5;
        v8 = v7 - v6;
        load_const(4, c);
        emit(i_type(OP_IMM, 5, 0, 4, int'(k)));
        emit(r_type(0, 4, 5, 0, 6));
        emit(r_type(0, 5, 6, 4, 7));
        emit(r_type(32, 6, 7, 0, 8));
        save(8, v8, 1'b1);
        // Load then use at once.
        emit(i_type(OP_LOAD, 9, 2, 0, 32'h10));
        emit(r_type(0, 8, 9, 0, 10));
        save(10, dmem[4] + v8, 1'b1);
        // Load data straight into a store.
        emit(i_type(OP_LOAD, 11, 2, 0, 32'h14));
        save(11, dmem[5], 1'b1);
        // Fresh base register for the address.
        load_const(13, 32'h1c);
        emit(i_type(OP_LOAD, 14, 2, 13, 0));
        save(14, dmem[7], 1'b1);
        finish_program();
        run_program("forward");
    endtask

    task automatic branch_loops();
        int          conds [6] = '{0, 1, 4, 5, 6, 7};
        int          starts [6] = '{4, 0, -3, 3, 1, 3};
        int          steps [6] = '{1, 1, 1, -1, 1, -1};
        int          lims [6] = '{5, 3, 1, 0, 4, 1};
        logic [31:0] x;
        int          n;
        bit          taken;
        begin_test();
        load_const(10, 32'hffff_ffff);
        load_const(11, 32'h1);
        for (int c = 0; c < 6; c++) begin
            load_const(1, starts[c]);
            load_const(2, lims[c]);
            emit(i_type(OP_IMM, 5, 0, 0, 0));
            // Loop body counts and steps, then branches back.
            emit(i_type(OP_IMM, 5, 0, 5, 1));
            emit(i_type(OP_IMM, 1, 0, 1, steps[c]));
            emit(b_type(conds[c], 1, 2, -8));
            x = starts[c];
            n = 0;
            do begin
                n++;
                x = x + steps[c];
            end while (branch_taken(conds[c], x, lims[c]));
            save(5, n, 1'b1);
            save(1, x, 1'b1);
            // Forward skips over two stores on pairs (-1,1), (1,-1), (1,1).
            for (int p = 0; p < 3; p++) begin
                emit(b_type(conds[c], (p == 0) ? 10 : 11, (p == 1) ? 10 : 11, 12));
                taken = branch_taken(conds[c], (p == 0) ? 32'hffff_ffff : 32'h1,
                                     (p == 1) ? 32'hffff_ffff : 32'h1);
                save(11, 32'h1, !taken);
                save(11, 32'h1, !taken);
            end
        end
        finish_program();
        run_program("branch");
    endtask

    task automatic jump_links();
        logic [31:0] pc;
        begin_test();
        pc = pc_now();
        emit(j_type(1, 12));
        save(11, 32'h0, 1'b0);
        save(11, 32'h0, 1'b0);
        save(1, pc + 32'd4, 1'b1);
        // Odd base plus offset loses bit 0.
        pc = pc_now();
        load_const(2, pc + 32'd20 - 32'd7);
        emit(i_type(OP_JALR, 3, 0, 2, 8));
        save(11, 32'h0, 1'b0);
        save(11, 32'h0, 1'b0);
        save(3, pc + 32'd12, 1'b1);
        finish_program();
        run_program("jump");
    endtask

    task automatic load_store();
        logic [31:0] k;
        logic [31:0] v1;
        begin_test();
        k = sext12($random(seed));
        v1 = dmem[8] + k;
        emit(i_type(OP_LOAD, 1, 2, 0, 32'h20));
        emit(i_type(OP_IMM, 1, 0, 1, int'(k)));
        emit(i_type(OP_LOAD, 2, 2, 0, 32'h24));
        emit(r_type(0, 2, 1, 4, 3));
        save(1, v1, 1'b1);
        save(3, v1 ^ dmem[9], 1'b1);
        save(2, dmem[9], 1'b1);
        finish_program();
        run_program("memory");
    endtask

// ==== bench/axo_core_tb.sv ====
// RV32I core testbench
`timescale 1ns/1ns

module axo_core_tb import axo_pkg::*; ();

    localparam int NUM_TESTS = 6;
    // Store here marks the end of a program.
    localparam logic [XLEN-1:0] END_ADDR = 32'h0000_0ffc;
    // First result address of every test.
    localparam logic [XLEN-1:0] SLOT_BASE = 32'h0000_0100;

    logic            clk;
    logic            rst_latch;
    logic            prog_re;
    logic [XLEN-1:0] prog_addr;
    logic [XLEN-1:0] prog_data;
    logic            mem_re;
    logic            mem_we;
    logic [XLEN-1:0] mem_addr;
    logic [XLEN-1:0] mem_wdata;
    logic [XLEN-1:0] mem_rdata;

    // Program words from ENTRY_PC and data words from address 0.
    logic [XLEN-1:0] prog_mem [0:1023];
    logic [XLEN-1:0] dmem [0:255];
    int              load_idx;
    // Next result address.
    logic [XLEN-1:0] slot;
    logic            end_seen;
    int              seed;
    // Observed and predicted stores.
    logic [XLEN-1:0] log_addr [$];
    logic [XLEN-1:0] log_data [$];
    logic [XLEN-1:0] exp_addr [$];
    logic [XLEN-1:0] exp_data [$];

    axo_core dut0 (
        .clk       (clk),
        .rst_latch (rst_latch),
        .prog_re   (prog_re),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .mem_re    (mem_re),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata)
    );

    // Both buses answer in the same cycle.
    assign prog_data = prog_mem[prog_addr[11:2]];
    // Data only comes back under a read strobe.
    assign mem_rdata = mem_re ? dmem[mem_addr[9:2]] : '0;

    // Stores are sampled mid-cycle on the settled bus.
    always @(negedge clk) begin
        if (!rst_latch && mem_we) begin
            if (mem_addr == END_ADDR) begin
                end_seen = 1'b1;
            end else begin
                dmem[mem_addr[9:2]] = mem_wdata;
                log_addr.push_back(mem_addr);
                log_data.push_back(mem_wdata);
            end
        end
    end

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    // Whole run bounded by 2000 cycles per test.
    initial begin
        repeat (2000 * NUM_TESTS) @(posedge clk);
        $display("no end store seen before timeout");
        $display("sim failed");
        $fatal(1);
    end

    task automatic report_mismatch(input string name, input logic [XLEN-1:0] expected,
                                   input logic [XLEN-1:0] actual);
        $display("[FAIL] %s expected %h actual %h", name, expected, actual);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic report_problem(input string what);
        $display("%s", what);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic emit(input logic [XLEN-1:0] insn);
        prog_mem[load_idx] = insn;
        load_idx++;
    endtask

    function automatic logic [XLEN-1:0] pc_now();
        return ENTRY_PC + 32'(4 * load_idx);
    endfunction

    // Core held in reset while a new program is written.
    task automatic begin_test();
        @(negedge clk);
        rst_latch = 1'b1;
        for (int i = 0; i < 1024; i++) begin
            prog_mem[i] = NOP_INSN;
        end
        load_idx = 0;
        slot = SLOT_BASE;
        end_seen = 1'b0;
        log_addr.delete();
        log_data.delete();
        exp_addr.delete();
        exp_data.delete();
    endtask

    task automatic run_program(input string name);
        repeat (4) begin
            @(negedge clk);
            assert (!mem_we && !mem_re && !prog_re)
                else report_problem("bus strobe active during reset");
            assert (!dut0.fd_valid && !dut0.dx0.valid)
                else report_problem("pipeline barrier valid during reset");
        end
        rst_latch = 1'b0;
        // One rising edge later.
        @(negedge clk);
        assert (prog_addr == ENTRY_PC)
            else report_mismatch({name, " entry"}, ENTRY_PC, prog_addr);
        while (!end_seen) begin
            @(posedge clk);
        end
        check_stores(name);
    endtask

    task automatic check_stores(input string name);
        assert (log_addr.size() == exp_addr.size())
            else report_mismatch({name, " store count"}, exp_addr.size(), log_addr.size());
        foreach (exp_addr[i]) begin
            assert (log_addr[i] == exp_addr[i])
                else report_mismatch({name, " store address"}, exp_addr[i], log_addr[i]);
            assert (log_data[i] == exp_data[i])
                else report_mismatch({name, " store data"}, exp_data[i], log_data[i]);
        end
    endtask

    `include "axo_core_tests.svh"

    initial begin
        rst_latch = 1'b1;
        end_seen = 1'b0;
        load_idx = 0;
        slot = SLOT_BASE;
        seed = 32'h51f4_ee96;
        for (int i = 0; i < 256; i++) begin
            dmem[i] = $random(seed);
        end
        for (int i = 0; i < 1024; i++) begin
            prog_mem[i] = NOP_INSN;
        end
        reset_entry();
        arith_ops();
        forward_chain();
        branch_loops();
        jump_links();
        load_store();
        $display("sim passed");
        $finish;
    end

endmodule

// ==== hdl/axo_core.sv ====
// Three stage RV32I core
`timescale 1ns/1ns

module axo_core import axo_pkg::*; (
    input  logic            clk,
    input  logic            rst_latch,
    output logic            prog_re,
    output logic [XLEN-1:0] prog_addr,
    input  logic [XLEN-1:0] prog_data,
    output logic            mem_re,
    output logic            mem_we,
    output logic [XLEN-1:0] mem_addr,
    output logic [XLEN-1:0] mem_wdata,
    input  logic [XLEN-1:0] mem_rdata
);
    // Fetch to decode barrier.
    logic            fd_valid;
    logic [XLEN-1:0] fd_pc;
    logic [XLEN-1:0] fd_insn;
    // Decode guess back to fetch.
    logic            predict_taken_now;
    logic [XLEN-1:0] predict_target;

    axo_dx_if dx0 (.clk(clk));

    axo_fetch fetch0 (
        .clk               (clk),
        .rst_latch         (rst_latch),
        .prog_data         (prog_data),
        .predict_taken_now (predict_taken_now),
        .predict_target    (predict_target),
        .redirect          (dx0.redirect),
        .redirect_pc       (dx0.redirect_pc),
        .prog_re           (prog_re),
        .prog_addr         (prog_addr),
        .fd_valid          (fd_valid),
        .fd_pc             (fd_pc),
        .fd_insn           (fd_insn)
    );

    axo_decode decode0 (
        .clk               (clk),
        .rst_latch         (rst_latch),
        .fd_valid          (fd_valid),
        .fd_pc             (fd_pc),
        .fd_insn           (fd_insn),
        .predict_taken_now (predict_taken_now),
        .predict_target    (predict_target),
        .dx                (dx0.decode)
    );

    axo_execute execute0 (
        .mem_rdata (mem_rdata),
        .mem_re    (mem_re),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .dx        (dx0.execute)
    );

endmodule

// ==== hdl/axo_execute.sv ====
// Execute stage
`timescale 1ns/1ns

module axo_execute import axo_pkg::*; (
    input  logic [XLEN-1:0] mem_rdata,
    output logic            mem_re,
    output logic            mem_we,
    output logic [XLEN-1:0] mem_addr,
    output logic [XLEN-1:0] mem_wdata,
    axo_dx_if.execute       dx
);
    // ALU result.
    logic [XLEN-1:0] alu_y;
    logic            is_load;
    logic            is_store;
    logic            is_branch;
    // Resolved branch outcome.
    logic            taken;

    axo_alu alu0 (
        .op (dx.alu_op),
        .a  (dx.lhs),
        .b  (dx.rhs),
        .y  (alu_y)
    );

    assign is_load   = dx.valid && dx.opcode == OP_LOAD;
    assign is_store  = dx.valid && dx.opcode == OP_STORE;
    assign is_branch = dx.valid && dx.opcode == OP_BRANCH;

    // Address adder beside the ALU.
    assign mem_addr  = dx.lhs + dx.imm;
    assign mem_re    = is_load;
    assign mem_we    = is_store;
    assign mem_wdata = dx.store_data;

    // Compare ops leave the outcome in bit 0.
    assign taken       = alu_y[0];
    assign dx.redirect = is_branch && (taken != dx.predict_taken);
    // Path that decode did not follow.
    assign dx.redirect_pc = taken ? dx.pc + dx.imm : dx.pc + XLEN'(4);

    // Writeback and bypass value.
    assign dx.fwd_rd    = dx.valid ? dx.rd : '0;
    assign dx.fwd_value = is_load ? mem_rdata : alu_y;

    // One memory access per instruction.
    a_mem_excl: assert property (@(posedge dx.clk) !(mem_re && mem_we))
        else $error("load and store strobes both high");

endmodule

// ==== hdl/axo_decode.sv ====
// Instruction decode stage
`timescale 1ns/1ns

module axo_decode import axo_pkg::*; (
    input  logic            clk,
    input  logic            rst_latch,
    input  logic            fd_valid,
    input  logic [XLEN-1:0] fd_pc,
    input  logic [XLEN-1:0] fd_insn,
    output logic            predict_taken_now,
    output logic [XLEN-1:0] predict_target,
    axo_dx_if.decode        dx
);
    opcode_e           opcode;
    logic [REG_AW-1:0] rs1;
    logic [REG_AW-1:0] rs2;
    logic [REG_AW-1:0] rd;
    logic [2:0]        funct3;
    logic [6:0]        funct7;
    logic [XLEN-1:0]   imm;
    logic [XLEN-1:0]   rs1_val;
    logic [XLEN-1:0]   rs2_val;
    logic [XLEN-1:0]   rs1_fwd;
    logic [XLEN-1:0]   rs2_fwd;
    logic [XLEN-1:0]   lhs;
    logic [XLEN-1:0]   rhs;
    alu_op_e           alu_op;
    logic              is_jump;
    logic              has_rd;
    logic              take;

    // Instruction fields.
    assign opcode = opcode_e'(fd_insn[6:0]);
    assign rd     = fd_insn[11:7];
    assign funct3 = fd_insn[14:12];
    assign rs1    = fd_insn[19:15];
    assign rs2    = fd_insn[24:20];
    assign funct7 = fd_insn[31:25];

    // Writes come from the instruction in execute.
    axo_regfile regs0 (
        .clk       (clk),
        .rst_latch (rst_latch),
        .rs1       (rs1),
        .rs2       (rs2),
        .we        (dx.fwd_rd != '0),
        .rd        (dx.fwd_rd),
        .wdata     (dx.fwd_value),
        .rs1_val   (rs1_val),
        .rs2_val   (rs2_val)
    );

    // Bypass from execute, zero fwd_rd means nothing to take.
    assign rs1_fwd = (rs1 != '0 && rs1 == dx.fwd_rd) ? dx.fwd_value : rs1_val;
    assign rs2_fwd = (rs2 != '0 && rs2 == dx.fwd_rd) ? dx.fwd_value : rs2_val;

    // Immediate per format.
    always_comb begin
        case (opcode)
            OP_LUI, OP_AUIPC: imm = {fd_insn[31:12], 12'b0};
            OP_JAL: imm = {{11{fd_insn[31]}}, fd_insn[31], fd_insn[19:12],
                           fd_insn[20], fd_insn[30:21], 1'b0};
            OP_BRANCH: imm = {{19{fd_insn[31]}}, fd_insn[31], fd_insn[7],
                              fd_insn[30:25], fd_insn[11:8], 1'b0};
            OP_STORE: imm = {{20{fd_insn[31]}}, fd_insn[31:25], fd_insn[11:7]};
            // I-type.
            default: imm = {{20{fd_insn[31]}}, fd_insn[31:20]};
        endcase
    end

    // ALU operation.
    always_comb begin
        alu_op = ALU_ADD;
        case (opcode)
            OP_BRANCH: begin
                case (funct3)
                    F3_BEQ:  alu_op = ALU_EQ;
                    F3_BNE:  alu_op = ALU_NE;
                    F3_BLT:  alu_op = ALU_SLT;
                    F3_BGE:  alu_op = ALU_GE;
                    F3_BLTU: alu_op = ALU_SLTU;
                    F3_BGEU: alu_op = ALU_GEU;
                    default: alu_op = ALU_EQ;
                endcase
            end
            OP_IMM, OP_REG: begin
                case (funct3)
                    // SUB only exists in the register form.
                    F3_ADD:  alu_op = (opcode == OP_REG && funct7 == F7_ALT) ? ALU_SUB : ALU_ADD;
                    F3_SLL:  alu_op = ALU_SLL;
                    F3_SLT:  alu_op = ALU_SLT;
                    F3_SLTU: alu_op = ALU_SLTU;
                    F3_XOR:  alu_op = ALU_XOR;
                    F3_SR:   alu_op = (funct7 == F7_ALT) ? ALU_SRA : ALU_SRL;
                    F3_OR:   alu_op = ALU_OR;
                    F3_AND:  alu_op = ALU_AND;
                    default: alu_op = ALU_ADD;
                endcase
            end
            default: alu_op = ALU_ADD;
        endcase
    end

    assign is_jump = (opcode == OP_JAL) || (opcode == OP_JALR);
    assign has_rd  = (opcode == OP_LUI) || (opcode == OP_AUIPC) || is_jump
                  || (opcode == OP_LOAD) || (opcode == OP_IMM) || (opcode == OP_REG);

    // Operands.
    always_comb begin
        if (is_jump || opcode == OP_AUIPC) begin
            lhs = fd_pc;
        end else if (opcode == OP_LUI) begin
            lhs = '0;
        end else begin
            lhs = rs1_fwd;
        end
        // Jumps link to the next word.
        if (is_jump) begin
            rhs = XLEN'(4);
        end else if (opcode == OP_REG || opcode == OP_BRANCH) begin
            rhs = rs2_fwd;
        end else begin
            rhs = imm;
        end
    end

    // Static guess: jumps always, branches when backward.
    assign take = is_jump || (opcode == OP_BRANCH && fd_insn[31]);
    assign predict_taken_now = fd_valid && !dx.redirect && take;
    assign predict_target = (opcode == OP_JALR) ? ((rs1_fwd + imm) & ~XLEN'(1)) : fd_pc + imm;

    // Barrier control.
    always_ff @(posedge clk) begin
        if (rst_latch) begin
            dx.valid         <= 1'b0;
            dx.rd            <= '0;
            dx.predict_taken <= 1'b0;
            dx.opcode        <= opcode_e'(NOP_INSN[6:0]);
        end else begin
            dx.valid         <= fd_valid && !dx.redirect;
            dx.rd            <= (fd_valid && !dx.redirect && has_rd) ? rd : '0;
            dx.predict_taken <= predict_taken_now;
            dx.opcode        <= opcode;
        end
    end

    // Barrier payload.
    always_ff @(posedge clk) begin
        dx.alu_op     <= alu_op;
        dx.lhs        <= lhs;
        dx.rhs        <= rhs;
        dx.imm        <= imm;
        dx.pc         <= fd_pc;
        dx.store_data <= rs2_fwd;
    end

    // A squashed slot must not write back in execute.
    a_rd_idle: assert property (@(posedge clk) disable iff (rst_latch)
        !dx.valid |-> dx.rd == '0)
        else $error("invalid barrier slot carries a destination");

endmodule

// ==== hdl/axo_fetch.sv ====
// Instruction fetch stage
`timescale 1ns/1ns

module axo_fetch import axo_pkg::*; (
    input  logic            clk,
    input  logic            rst_latch,
    input  logic [XLEN-1:0] prog_data,
    input  logic            predict_taken_now,
    input  logic [XLEN-1:0] predict_target,
    input  logic            redirect,
    input  logic [XLEN-1:0] redirect_pc,
    output logic            prog_re,
    output logic [XLEN-1:0] prog_addr,
    output logic            fd_valid,
    output logic [XLEN-1:0] fd_pc,
    output logic [XLEN-1:0] fd_insn
);
    // Current fetch address.
    logic [XLEN-1:0] pc;
    // Address for the next cycle.
    logic [XLEN-1:0] next_pc;

    assign prog_addr = pc;

    // Correction from execute beats the decode guess.
    always_comb begin
        if (redirect) begin
            next_pc = redirect_pc;
        end else if (predict_taken_now) begin
            next_pc = predict_target;
        end else begin
            next_pc = pc + XLEN'(4);
        end
    end

    // PC holds ENTRY_PC for the first cycle after release.
    always_ff @(posedge clk) begin
        if (rst_latch) begin
            prog_re  <= 1'b0;
            pc       <= ENTRY_PC;
            fd_valid <= 1'b0;
            fd_insn  <= NOP_INSN;
        end else begin
            prog_re <= 1'b1;
            if (prog_re) begin
                pc <= next_pc;
            end
            // Word fetched under a redirect or a taken guess is dropped.
            fd_valid <= prog_re && !redirect && !predict_taken_now;
            fd_insn  <= prog_data;
        end
    end

    // Barrier PC.
    always_ff @(posedge clk) begin
        fd_pc <= pc;
    end

    // All targets are word aligned without the C extension.
    a_prog_aligned: assert property (@(posedge clk) disable iff (rst_latch)
        prog_addr[1:0] == 2'b00)
        else $error("prog_addr not word aligned");

endmodule

// ==== hdl/axo_regfile.sv ====
// Integer register file
`timescale 1ns/1ns

module axo_regfile import axo_pkg::*; (
    input  logic              clk,
    input  logic              rst_latch,
    input  logic [REG_AW-1:0] rs1,
    input  logic [REG_AW-1:0] rs2,
    input  logic              we,
    input  logic [REG_AW-1:0] rd,
    input  logic [XLEN-1:0]   wdata,
    output logic [XLEN-1:0]   rs1_val,
    output logic [XLEN-1:0]   rs2_val
);
    // x1 to x31; x0 is not stored.
    logic [XLEN-1:0] regs [1:31];

    // Reads are combinational, x0 gives zero.
    assign rs1_val = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_val = (rs2 == '0) ? '0 : regs[rs2];

    always_ff @(posedge clk) begin
        if (rst_latch) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin
            regs[rd] <= wdata;
        end
    end

    // Execute never reports x0 as its destination.
    a_no_x0_write: assert property (@(posedge clk) disable iff (rst_latch)
        we |-> rd != '0)
        else $error("register write addressed to x0");

endmodule

// ==== hdl/axo_alu.sv ====
// RV32I arithmetic unit
`timescale 1ns/1ns

module axo_alu import axo_pkg::*; (
    input  alu_op_e         op,
    input  logic [XLEN-1:0] a,
    input  logic [XLEN-1:0] b,
    output logic [XLEN-1:0] y
);
    // Shift amount.
    logic [4:0] sh;
    // Single-bit compare result.
    logic       flag;

    assign sh = b[4:0];

    always_comb begin
        flag = 1'b0;
        y    = '0;
        case (op)
            ALU_ADD:  y = a + b;
            ALU_SUB:  y = a - b;
            ALU_SLL:  y = a << sh;
            ALU_XOR:  y = a ^ b;
            ALU_SRL:  y = a >> sh;
            ALU_SRA:  y = $signed(a) >>> sh;
            ALU_OR:   y = a | b;
            ALU_AND:  y = a & b;
            // Compares, also used by branches.
            ALU_SLT: begin
                flag = $signed(a) < $signed(b);
                y    = {{(XLEN-1){1'b0}}, flag};
            end
            ALU_SLTU: begin
                flag = a < b;
                y    = {{(XLEN-1){1'b0}}, flag};
            end
            ALU_EQ: begin
                flag = a == b;
                y    = {{(XLEN-1){1'b0}}, flag};
            end
            ALU_NE: begin
                flag = a != b;
                y    = {{(XLEN-1){1'b0}}, flag};
            end
            ALU_GE: begin
                flag = $signed(a) >= $signed(b);
                y    = {{(XLEN-1){1'b0}}, flag};
            end
            ALU_GEU: begin
                flag = a >= b;
                y    = {{(XLEN-1){1'b0}}, flag};
            end
            default: y = '0;
        endcase
    end

endmodule

// ==== hdl/axo_dx_if.sv ====
// Decode to execute barrier bundle
`timescale 1ns/1ns

interface axo_dx_if import axo_pkg::*; (
    input logic clk
);
    // Barrier contents, driven by decode.
    logic              valid;
    logic [REG_AW-1:0] rd;
    alu_op_e           alu_op;
    logic [XLEN-1:0]   lhs;
    logic [XLEN-1:0]   rhs;
    logic [XLEN-1:0]   imm;
    logic [XLEN-1:0]   pc;
    opcode_e           opcode;
    logic [XLEN-1:0]   store_data;
    logic              predict_taken;

    // Result and correction, driven by execute.
    logic [REG_AW-1:0] fwd_rd;
    logic [XLEN-1:0]   fwd_value;
    logic              redirect;
    logic [XLEN-1:0]   redirect_pc;

    modport decode (
        output valid, rd, alu_op, lhs, rhs, imm, pc, opcode, store_data, predict_taken,
        input  fwd_rd, fwd_value, redirect
    );

    modport execute (
        input  clk,
        input  valid, rd, alu_op, lhs, rhs, imm, pc, opcode, store_data, predict_taken,
        output fwd_rd, fwd_value, redirect, redirect_pc
    );
endinterface

// ==== hdl/axo_pkg.sv ====
// RV32I core shared definitions
package axo_pkg;

    // Data path width.
    localparam int XLEN = 32;
    // Register number width.
    localparam int REG_AW = 5;

    // First fetch address after reset.
    localparam logic [XLEN-1:0] ENTRY_PC = 32'h0000_1000;
    // ADDI x0, x0, 0.
    localparam logic [XLEN-1:0] NOP_INSN = 32'h0000_0013;

    // Major opcodes of the kept instruction set.
    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011
    } opcode_e;

    // Funct3 for OP and OP-IMM.
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // Funct3 for conditional branches.
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // Funct7 selecting SUB and SRA.
    localparam logic [6:0] F7_ALT = 7'b0100000;

    // ALU operations; compare ops give 0 or 1.
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_EQ,
        ALU_NE,
        ALU_GE,
        ALU_GEU
    } alu_op_e;

endpackage
